// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lookup_engine
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Test passed

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$($(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: list.f
logic/lookup_pkg.sv
logic/action_ram.sv
logic/cam_match.sv
logic/lookup_ctrl.sv
logic/table_loader.sv
logic/lookup_engine.sv
testbench/lookup_engine_assert.sv
testbench/tb_lookup_engine.sv

// File: logic/action_ram.sv
`timescale 1ns/10ps

module action_ram (
    input  logic                          clk,
    input  logic                          wr_en,
    input  logic [lookup_pkg::IDX_W-1:0]  wr_idx,
    input  logic [lookup_pkg::ACT_W-1:0]  wr_data,
    input  logic                          rd_en,
    input  logic [lookup_pkg::IDX_W-1:0]  rd_idx,
    output logic [lookup_pkg::ACT_W-1:0]  rd_data
);
    import lookup_pkg::*;

    logic [ACT_W-1:0] mem [TABLE_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // Output register holds its value between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

// File: logic/cam_match.sv
`timescale 1ns/10ps

module cam_match (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [lookup_pkg::KEY_W-1:0]  extract_key,
    input  logic [lookup_pkg::KEY_W-1:0]  extract_mask,
    input  logic                          wr_en,
    input  logic [lookup_pkg::IDX_W-1:0]  wr_idx,
    input  logic [lookup_pkg::KEY_W-1:0]  wr_key,
    output logic                          match,
    output logic [lookup_pkg::IDX_W-1:0]  match_idx
);
    import lookup_pkg::*;

    logic [KEY_W-1:0]        entry_key [TABLE_DEPTH];
    logic [TABLE_DEPTH-1:0]  entry_valid;
    logic [TABLE_DEPTH-1:0]  hit_vec;
    logic [IDX_W-1:0]        first_idx;

    // Stored keys
    always_ff @(posedge clk) begin
        if (wr_en) begin
            entry_key[wr_idx] <= wr_key;
        end
    end

    // Entries stay invalid until written once
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (wr_en) begin
            entry_valid[wr_idx] <= 1'b1;
        end
    end

    // Mask bit set means don't care
    always_comb begin
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            hit_vec[i] = entry_valid[i] &&
                         (((entry_key[i] ^ extract_key) & ~extract_mask) == '0);
        end
    end

    // Lowest index wins, so scan from the top down
    always_comb begin
        first_idx = '0;
        for (int i = TABLE_DEPTH - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                first_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match     <= 1'b0;
            match_idx <= '0;
        end else begin
            match     <= |hit_vec;
            match_idx <= first_idx;
        end
    end

endmodule

// File: logic/lookup_ctrl.sv
`timescale 1ns/10ps

module lookup_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          key_valid,
    input  logic [lookup_pkg::PHV_W-1:0]  phv_in,
    input  logic                          match,
    output logic                          act_rd_en,
    input  logic [lookup_pkg::ACT_W-1:0]  act_rd_data,
    output logic [lookup_pkg::ACT_W-1:0]  action,
    output logic                          action_valid,
    output logic [lookup_pkg::PHV_W-1:0]  phv_out
);
    import lookup_pkg::*;

    lookup_state_t     state;
    logic [PHV_W-1:0]  phv_reg;
    logic              accept;
    logic              issue_miss;
    logic              issue_hit;

    // New keys are only taken while idle, there is no back-pressure
    assign accept = (state == LK_IDLE) && key_valid;

    // CAM result is registered, so it belongs to the key taken last cycle
    assign act_rd_en  = (state == LK_MATCH) && match;
    assign issue_miss = (state == LK_MATCH) && !act_rd_en;
    assign issue_hit  = (state == LK_READ);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= LK_IDLE;
            action_valid <= 1'b0;
        end else begin
            action_valid <= 1'b0;
            case (state)
                LK_IDLE: begin
                    if (accept) begin
                        state <= LK_MATCH;
                    end
                end
                LK_MATCH: begin
                    if (act_rd_en) begin
                        state <= LK_READ;
                    end else begin
                        // Miss: default action goes out right away
                        action_valid <= 1'b1;
                        state        <= LK_IDLE;
                    end
                end
                LK_READ: begin
                    action_valid <= 1'b1;
                    state        <= LK_IDLE;
                end
                default: begin
                    state <= LK_IDLE;
                end
            endcase
        end
    end

    // PHV held while the lookup is in flight
    always_ff @(posedge clk) begin
        if (accept) begin
            phv_reg <= phv_in;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_miss) begin
            action  <= DEFAULT_ACTION;
            phv_out <= phv_reg;
        end else if (issue_hit) begin
            action  <= act_rd_data;
            phv_out <= phv_reg;
        end
    end

endmodule

// File: logic/lookup_engine.sv
`timescale 1ns/10ps

module lookup_engine #(
    parameter logic [lookup_pkg::STAGE_ID_W-1:0]  STAGE_ID  = '0,
    parameter logic [lookup_pkg::LOOKUP_ID_W-1:0] LOOKUP_ID = 3'd2
) (
    input  logic                           clk,
    input  logic                           rst_n,

    // From the key extractor
    input  logic [lookup_pkg::KEY_W-1:0]   extract_key,
    input  logic [lookup_pkg::KEY_W-1:0]   extract_mask,
    input  logic                           key_valid,
    input  logic [lookup_pkg::PHV_W-1:0]   phv_in,

    // To the action engine
    output logic [lookup_pkg::ACT_W-1:0]   action,
    output logic                           action_valid,
    output logic [lookup_pkg::PHV_W-1:0]   phv_out,

    // Table control stream
    input  logic [lookup_pkg::DATA_W-1:0]  ctrl_tdata,
    input  logic                           ctrl_tvalid,
    input  logic                           ctrl_tlast
);
    import lookup_pkg::*;

    logic              cam_wr_en;
    logic [IDX_W-1:0]  cam_wr_idx;
    logic [KEY_W-1:0]  cam_wr_key;
    logic              act_wr_en;
    logic [IDX_W-1:0]  act_wr_idx;
    logic [ACT_W-1:0]  act_wr_data;

    logic              match;
    logic [IDX_W-1:0]  match_idx;
    logic              act_rd_en;
    logic [ACT_W-1:0]  act_rd_data;

    lookup_ctrl lookup_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .phv_in       (phv_in),
        .match        (match),
        .act_rd_en    (act_rd_en),
        .act_rd_data  (act_rd_data),
        .action       (action),
        .action_valid (action_valid),
        .phv_out      (phv_out)
    );

    cam_match cam_match_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .extract_key  (extract_key),
        .extract_mask (extract_mask),
        .wr_en        (cam_wr_en),
        .wr_idx       (cam_wr_idx),
        .wr_key       (cam_wr_key),
        .match        (match),
        .match_idx    (match_idx)
    );

    // Read address comes straight from the registered CAM result
    action_ram action_ram_inst (
        .clk     (clk),
        .wr_en   (act_wr_en),
        .wr_idx  (act_wr_idx),
        .wr_data (act_wr_data),
        .rd_en   (act_rd_en),
        .rd_idx  (match_idx),
        .rd_data (act_rd_data)
    );

    table_loader #(
        .STAGE_ID  (STAGE_ID),
        .LOOKUP_ID (LOOKUP_ID)
    ) table_loader_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl_tdata  (ctrl_tdata),
        .ctrl_tvalid (ctrl_tvalid),
        .ctrl_tlast  (ctrl_tlast),
        .cam_wr_en   (cam_wr_en),
        .cam_wr_idx  (cam_wr_idx),
        .cam_wr_key  (cam_wr_key),
        .act_wr_en   (act_wr_en),
        .act_wr_idx  (act_wr_idx),
        .act_wr_data (act_wr_data)
    );

endmodule

// File: logic/lookup_pkg.sv
package lookup_pkg;

    // Datapath widths
    localparam int DATA_W      = 64;
    localparam int KEY_W       = 40;
    localparam int ACT_W       = 96;
    localparam int PHV_W       = 128;

    // Table geometry
    localparam int TABLE_DEPTH = 16;
    localparam int IDX_W       = 4;

    // Upper part of an action entry, carried by its second beat
    localparam int ACT_HI_W    = ACT_W - DATA_W;

    // Returned when no CAM entry matches
    localparam logic [ACT_W-1:0] DEFAULT_ACTION = ACT_W'('h3f);

    // Header beat layout
    localparam int MOD_ID_LSB    = 32;
    localparam int MOD_ID_W      = 8;
    localparam int STAGE_ID_W    = 5;
    localparam int LOOKUP_ID_W   = 3;
    localparam int TABLE_SEL_LSB = 40;
    localparam int TABLE_SEL_W   = 4;
    localparam int INDEX_LSB     = 48;

    // Target table; anything other than zero selects the action table
    typedef enum logic [TABLE_SEL_W-1:0] {
        TBL_CAM    = 4'd0,
        TBL_ACTION = 4'd1
    } table_sel_t;

    typedef enum logic [1:0] {
        LK_IDLE  = 2'd0,
        LK_MATCH = 2'd1,
        LK_READ  = 2'd2
    } lookup_state_t;

    typedef enum logic [2:0] {
        LD_IDLE   = 3'd0,
        LD_CAM    = 3'd1,
        LD_ACT_LO = 3'd2,
        LD_ACT_HI = 3'd3,
        LD_SKIP   = 3'd4
    } loader_state_t;

endpackage

// File: logic/table_loader.sv
`timescale 1ns/10ps

module table_loader #(
    parameter logic [lookup_pkg::STAGE_ID_W-1:0]  STAGE_ID  = '0,
    parameter logic [lookup_pkg::LOOKUP_ID_W-1:0] LOOKUP_ID = 3'd2
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [lookup_pkg::DATA_W-1:0]  ctrl_tdata,
    input  logic                           ctrl_tvalid,
    input  logic                           ctrl_tlast,
    output logic                           cam_wr_en,
    output logic [lookup_pkg::IDX_W-1:0]   cam_wr_idx,
    output logic [lookup_pkg::KEY_W-1:0]   cam_wr_key,
    output logic                           act_wr_en,
    output logic [lookup_pkg::IDX_W-1:0]   act_wr_idx,
    output logic [lookup_pkg::ACT_W-1:0]   act_wr_data
);
    import lookup_pkg::*;

    loader_state_t        state;
    logic [MOD_ID_W-1:0]  hdr_mod_id;
    table_sel_t           hdr_sel;
    logic                 hdr_hit;
    logic [IDX_W-1:0]     wr_idx;
    logic [DATA_W-1:0]    act_lo;

    // Header decode, only meaningful on a header beat
    assign hdr_mod_id = ctrl_tdata[MOD_ID_LSB +: MOD_ID_W];
    assign hdr_sel    = table_sel_t'(ctrl_tdata[TABLE_SEL_LSB +: TABLE_SEL_W]);
    assign hdr_hit    = (hdr_mod_id[MOD_ID_W-1 -: STAGE_ID_W] == STAGE_ID) &&
                        (hdr_mod_id[LOOKUP_ID_W-1:0] == LOOKUP_ID);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= LD_IDLE;
            wr_idx    <= '0;
            cam_wr_en <= 1'b0;
            act_wr_en <= 1'b0;
        end else begin
            cam_wr_en <= 1'b0;
            act_wr_en <= 1'b0;
            if (!ctrl_tvalid) begin
                // Gap inside a packet drops it, half entries included
                state <= LD_IDLE;
            end else begin
                case (state)
                    LD_IDLE: begin
                        wr_idx <= ctrl_tdata[INDEX_LSB +: IDX_W];
                        if (ctrl_tlast) begin
                            state <= LD_IDLE;
                        end else if (!hdr_hit) begin
                            state <= LD_SKIP;
                        end else if (hdr_sel == TBL_CAM) begin
                            state <= LD_CAM;
                        end else begin
                            state <= LD_ACT_LO;
                        end
                    end
                    LD_CAM: begin
                        cam_wr_en <= 1'b1;
                        wr_idx    <= wr_idx + 1'b1;
                        if (ctrl_tlast) begin
                            state <= LD_IDLE;
                        end
                    end
                    LD_ACT_LO: begin
                        // A packet ending here leaves an unfinished entry
                        state <= ctrl_tlast ? LD_IDLE : LD_ACT_HI;
                    end
                    LD_ACT_HI: begin
                        act_wr_en <= 1'b1;
                        wr_idx    <= wr_idx + 1'b1;
                        state     <= ctrl_tlast ? LD_IDLE : LD_ACT_LO;
                    end
                    LD_SKIP: begin
                        if (ctrl_tlast) begin
                            state <= LD_IDLE;
                        end
                    end
                    default: begin
                        state <= LD_IDLE;
                    end
                endcase
            end
        end
    end

    // First half of an action entry
    always_ff @(posedge clk) begin
        if (ctrl_tvalid && (state == LD_ACT_LO)) begin
            act_lo <= ctrl_tdata;
        end
    end

    // Write payload follows every beat, the strobes decide what lands
    always_ff @(posedge clk) begin
        cam_wr_idx  <= wr_idx;
        cam_wr_key  <= ctrl_tdata[KEY_W-1:0];
        act_wr_idx  <= wr_idx;
        act_wr_data <= {ctrl_tdata[ACT_HI_W-1:0], act_lo};
    end

endmodule

// File: testbench/lookup_engine_assert.sv
`timescale 1ns/10ps

module lookup_engine_assert (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       key_valid,
    input  lookup_pkg::lookup_state_t  lk_state,
    input  logic                       action_valid,
    input  logic                       cam_wr_en,
    input  logic                       act_wr_en
);
    import lookup_pkg::*;

    logic accepted;

    // Key taken by the lookup FSM
    assign accepted = key_valid && (lk_state == LK_IDLE);

    assert property (@(posedge clk) disable iff (!rst_n)
        action_valid |=> !action_valid)
        else $error("action_valid high for two cycles in a row");

    // Only one table written per cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        !(cam_wr_en && act_wr_en))
        else $error("CAM and action RAM written in the same cycle");

    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(action_valid) |-> ($past(accepted, 2) || $past(accepted, 3)))
        else $error("action_valid not 2 or 3 cycles after an accepted key");

endmodule

bind lookup_engine lookup_engine_assert lookup_engine_assert_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .key_valid    (key_valid),
    .lk_state     (lookup_ctrl_inst.state),
    .action_valid (action_valid),
    .cam_wr_en    (cam_wr_en),
    .act_wr_en    (act_wr_en)
);

// File: testbench/tb_lookup_engine.sv
`timescale 1ns/10ps

module tb_lookup_engine;
    import lookup_pkg::*;

    localparam logic [4:0]       STAGE_ID    = 5'd0;
    localparam logic [2:0]       LOOKUP_ID   = 3'd2;
    localparam logic [7:0]       OWN_ID      = {STAGE_ID, LOOKUP_ID};
    localparam logic [ACT_W-1:0] MISS_ACTION = 'h3f;

    localparam int HALF_PERIOD   = 20;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_CYCLES  = 4;
    localparam int MAX_PACKETS   = 10;
    localparam int PACKET_CYCLES = 40;
    localparam int MAX_LOOKUPS   = 60;
    localparam int LOOKUP_CYCLES = 8;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + MAX_PACKETS * PACKET_CYCLES +
                                    MAX_LOOKUPS * LOOKUP_CYCLES + 50;

    logic              clk;
    logic              rst_n;
    logic [KEY_W-1:0]  extract_key;
    logic [KEY_W-1:0]  extract_mask;
    logic              key_valid;
    logic [PHV_W-1:0]  phv_in;
    logic [ACT_W-1:0]  action;
    logic              action_valid;
    logic [PHV_W-1:0]  phv_out;
    logic [DATA_W-1:0] ctrl_tdata;
    logic              ctrl_tvalid;
    logic              ctrl_tlast;

    // Reference tables
    logic [KEY_W-1:0]  ref_key [TABLE_DEPTH];
    logic              ref_valid [TABLE_DEPTH];
    logic [ACT_W-1:0]  ref_act [TABLE_DEPTH];

    logic [31:0]       lcg_state;
    int                cycle_count = 0;
    logic [DATA_W-1:0] beat_q [$];

    lookup_engine #(
        .STAGE_ID  (STAGE_ID),
        .LOOKUP_ID (LOOKUP_ID)
    ) lookup_engine_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .extract_key  (extract_key),
        .extract_mask (extract_mask),
        .key_valid    (key_valid),
        .phv_in       (phv_in),
        .action       (action),
        .action_valid (action_valid),
        .phv_out      (phv_out),
        .ctrl_tdata   (ctrl_tdata),
        .ctrl_tvalid  (ctrl_tvalid),
        .ctrl_tlast   (ctrl_tlast)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("Timed out after %0d clock cycles", cycle_count));
        end
    end

    // Two LCG steps, upper halves only
    function automatic logic [31:0] lcg_next();
        logic [31:0] hi;
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        hi        = lcg_state;
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {hi[31:16], lcg_state[31:16]};
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        hi = lcg_next();
        return {hi, lcg_next()};
    endfunction

    // Random slot, moved up to the next valid one
    function automatic int pick_valid_index();
        logic [31:0] r;
        int          idx;
        r   = lcg_next();
        idx = r[3:0];
        while (!ref_valid[idx]) begin
            idx = (idx + 1) % TABLE_DEPTH;
        end
        return idx;
    endfunction

    task automatic compare_value(input string name, input logic [PHV_W-1:0] actual,
                                 input logic [PHV_W-1:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("[FAIL] %s: actual 0x%0h, expected 0x%0h",
                                        name, actual, expected));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic queue_random(input int count);
        repeat (count) begin
            beat_q.push_back(rand64());
        end
    endtask

    // Lowest valid slot whose unmasked bits agree with the key
    task automatic predict_result(input logic [KEY_W-1:0] key, input logic [KEY_W-1:0] mask,
                                  output logic [ACT_W-1:0] exp_act, output int exp_lat);
        exp_act = MISS_ACTION;
        exp_lat = 2;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            if (ref_valid[i] && ((ref_key[i] & ~mask) == (key & ~mask))) begin
                exp_act = ref_act[i];
                exp_lat = 3;
                break;
            end
        end
    endtask

    // Header, then the queued data beats; cut_after >= 0 drops tvalid after that many
    task automatic send_packet(input logic [7:0] mod_id, input logic [3:0] sel,
                               input logic [7:0] start, input int cut_after);
        logic [31:0]       r;
        logic [DATA_W-1:0] beat;
        int                sent;
        sent = beat_q.size();
        if (cut_after >= 0 && cut_after < sent) begin
            sent = cut_after;
        end
        r           = lcg_next();
        ctrl_tdata  = {r[31:24], start, r[23:20], sel, mod_id, lcg_next()};
        ctrl_tvalid = 1'b1;
        ctrl_tlast  = 1'b0;
        next_cycle();
        for (int n = 0; n < sent; n++) begin
            beat       = beat_q[n];
            ctrl_tdata = beat;
            ctrl_tlast = (n == beat_q.size() - 1);
            next_cycle();
            if (mod_id == OWN_ID && sel == 4'd0) begin
                ref_key[(start[3:0] + n) % TABLE_DEPTH]   = beat[KEY_W-1:0];
                ref_valid[(start[3:0] + n) % TABLE_DEPTH] = 1'b1;
            end else if (mod_id == OWN_ID && n % 2 == 1) begin
                // Entry lands with its upper beat
                ref_act[(start[3:0] + n / 2) % TABLE_DEPTH] = {beat[31:0], beat_q[n - 1]};
            end
        end
        ctrl_tvalid = 1'b0;
        ctrl_tlast  = 1'b0;
        beat_q.delete();
        next_cycle();
        next_cycle();
    endtask

    task automatic run_lookup(input logic [KEY_W-1:0] key, input logic [KEY_W-1:0] mask);
        logic [PHV_W-1:0] phv;
        logic [ACT_W-1:0] exp_act;
        int               exp_lat;
        int               lat;
        phv = {rand64(), rand64()};
        predict_result(key, mask, exp_act, exp_lat);
        extract_key  = key;
        extract_mask = mask;
        phv_in       = phv;
        key_valid    = 1'b1;
        next_cycle();
        key_valid    = 1'b0;
        // Key lines are don't care once sampled
        extract_key  = KEY_W'(rand64());
        phv_in       = {rand64(), rand64()};
        lat          = 1;
        while (action_valid !== 1'b1) begin
            if (lat >= LOOKUP_CYCLES) begin
                stop_with_failure("No action_valid came back for an accepted key");
            end
            next_cycle();
            lat++;
        end
        compare_value("action_valid latency", PHV_W'(lat), PHV_W'(exp_lat));
        compare_value("action", PHV_W'(action), PHV_W'(exp_act));
        compare_value("phv_out", phv_out, phv);
        next_cycle();
        compare_value("action_valid", PHV_W'(action_valid), '0);
        next_cycle();
    endtask

    initial begin
        logic [31:0]      r;
        logic [KEY_W-1:0] key;
        logic [KEY_W-1:0] mask;
        int               idx;
        int               bit_pos;
        lcg_state    = 32'd35;
        rst_n        = 1'b0;
        key_valid    = 1'b0;
        extract_key  = '0;
        extract_mask = '0;
        phv_in       = '0;
        ctrl_tdata   = '0;
        ctrl_tvalid  = 1'b0;
        ctrl_tlast   = 1'b0;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            ref_valid[i] = 1'b0;
            ref_key[i]   = '0;
            ref_act[i]   = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        next_cycle();

        // Empty tables, every key misses
        repeat (8) run_lookup(KEY_W'(rand64()), KEY_W'(rand64()));

        // Ten keys from slot 11..14 wrap past 15, then all 16 actions
        r = lcg_next();
        queue_random(10);
        send_packet(OWN_ID, 4'd0, 8'd11 + 8'(r[1:0]), -1);
        queue_random(32);
        send_packet(OWN_ID, 4'd1, r[15:8], -1);
        // Any non-zero select also means the action table
        queue_random(6);
        send_packet(OWN_ID, r[19:16] | 4'h2, r[31:24], -1);
        queue_random(4);
        send_packet(OWN_ID, 4'd0, 8'(lcg_next()), -1);
        repeat (12) begin
            idx = pick_valid_index();
            run_lookup(ref_key[idx], '0);
        end

        // Differences only under the mask
        repeat (8) begin
            idx  = pick_valid_index();
            mask = KEY_W'(rand64());
            run_lookup(ref_key[idx] ^ (KEY_W'(rand64()) & mask), mask);
        end
        // One unmasked bit flipped as well
        repeat (8) begin
            idx           = pick_valid_index();
            r             = lcg_next();
            bit_pos       = r % KEY_W;
            mask          = KEY_W'(rand64());
            mask[bit_pos] = 1'b0;
            key           = ref_key[idx] ^ (KEY_W'(rand64()) & mask);
            key[bit_pos]  = ~key[bit_pos];
            run_lookup(key, mask);
        end

        // Same key in three slots
        key = KEY_W'(rand64());
        for (int n = 0; n < 5; n++) begin
            beat_q.push_back((n % 2 == 0) ? {24'(lcg_next()), key} : rand64());
        end
        send_packet(OWN_ID, 4'd0, 8'(lcg_next()), -1);
        run_lookup(key, '0);
        // All bits masked gives the lowest valid slot
        run_lookup(KEY_W'(rand64()), '1);

        // Stage ID and lookup ID mismatch
        queue_random(4);
        send_packet({STAGE_ID ^ 5'h11, LOOKUP_ID}, 4'd0, 8'(lcg_next()), -1);
        queue_random(4);
        send_packet({STAGE_ID, LOOKUP_ID ^ 3'h5}, 4'd1, 8'(lcg_next()), -1);
        // Gaps: one action entry and two keys survive
        queue_random(6);
        send_packet(OWN_ID, 4'd1, 8'(lcg_next()), 3);
        queue_random(4);
        send_packet(OWN_ID, 4'd0, 8'(lcg_next()), 2);
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            if (ref_valid[i]) begin
                run_lookup(ref_key[i], '0);
            end
        end

        $display("Test passed");
        $finish;
    end

endmodule
